// File: src.f
mac_pkg.sv
crc_pkg.sv
rx_crc64.sv
mac_hard_crc.sv
frame_fifo.sv
fcs_append.sv
mac_tx_fcs.sv
mac_tx_fcs_assertions.sv
tb_mac_tx_fcs.sv

// File: Makefile
TOP = tb_mac_tx_fcs

all: run

run: build
	./obj_dir/V$(TOP)

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir

.PHONY: all run build lint clean

// File: tb_mac_tx_fcs.sv
`timescale 1ns/1ps

module tb_mac_tx_fcs;
  import mac_pkg::*;

  logic       clk = 1'b0;
  logic       arst_n;
  mac_word_t  din;
  mac_word_t  out;
  logic       overflow;
  integer     seed;
  logic [8:0] model_q[$];   // Expected output bytes, bit 8 marks the frame end.
  int         frame_len[$];
  int         directed_len [16] = '{1, 2, 3, 4, 9, 12, 5, 6, 7, 8, 13, 16, 1, 1, 8, 8};
  int         cycle_count = 0;
  int         cycle_limit;

  mac_tx_fcs i_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .din      (din),
    .out      (out),
    .overflow (overflow)
  );

  always #2 clk = ~clk;

  // Bytewise reflected CRC-32, result complemented.
  function automatic logic [31:0] crc32_ref(input logic [7:0] frame [64], input int len);
    logic [31:0] c;
    c = 32'hFFFF_FFFF;
    for (int i = 0; i < len; i++) begin
      c = c ^ {24'b0, frame[i]};
      for (int k = 0; k < 8; k++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic report_value_error(input string name, input logic [63:0] exp_val,
                                    input logic [63:0] act_val);
    $display("error: time %0t signal %s expected %h actual %h", $time, name, exp_val, act_val);
    stop_on_failure();
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) report_value_error(name, 64'(exp_val), 64'(act_val));
  endtask

  task automatic check_word(input mac_word_t exp, input mac_word_t got);
    logic [LANES*8-1:0] mask;
    mask = '0;
    for (int i = 0; i < LANES; i++) begin
      if (exp.keep[i]) mask[8*i +: 8] = 8'hff; // Only valid lanes carry data.
    end
    if (got.keep !== exp.keep) report_value_error("out.keep", 64'(exp.keep), 64'(got.keep));
    else if (got.last !== exp.last) report_value_error("out.last", 64'(exp.last), 64'(got.last));
    else if ((got.data & mask) !== (exp.data & mask))
      report_value_error("out.data", exp.data & mask, got.data & mask);
  endtask

  // Packs the next bytes of the model into one expected word.
  task automatic compare_output(input mac_word_t got);
    mac_word_t  exp;
    logic [8:0] b;
    int         n;
    exp = '0;
    exp.valid = 1'b1;
    n = 0;
    if (model_q.size() == 0) begin
      $display("unexpected output word at %0t with nothing left in the model", $time);
      stop_on_failure();
    end else begin
      while (n < LANES && model_q.size() != 0 && !exp.last) begin
        b = model_q.pop_front();
        exp.data[8*n +: 8] = b[7:0];
        exp.keep[n] = 1'b1;
        exp.last = b[8];
        n++;
      end
      check_word(exp, got);
    end
  endtask

  task automatic send_frame(input int len);
    logic [7:0]  frame [64];
    logic [31:0] fcs;
    mac_word_t   w;
    int          nwords;
    int          gap;
    for (int i = 0; i < 64; i++) begin
      frame[i] = (i < len) ? 8'($random(seed)) : 8'h00;
    end
    fcs = crc32_ref(frame, len);
    for (int i = 0; i < len; i++) begin
      model_q.push_back({1'b0, frame[i]});
    end
    for (int i = 0; i < 4; i++) begin
      model_q.push_back({(i == 3), fcs[8*i +: 8]}); // FCS goes out LSB first.
    end
    nwords = (len + LANES - 1) / LANES;
    for (int wi = 0; wi < nwords; wi++) begin
      w = '0;
      w.valid = 1'b1;
      for (int l = 0; l < LANES; l++) begin
        if (wi * LANES + l < len) begin
          w.data[8*l +: 8] = frame[wi * LANES + l];
          w.keep[l] = 1'b1;
        end
      end
      w.last = (wi == nwords - 1);
      @(negedge clk);
      din = w;
    end
    gap = 1 + int'($unsigned($random(seed)) % 3);
    repeat (gap) begin
      @(negedge clk);
      din = '0;
    end
  endtask

  task automatic wait_drain();
    while (model_q.size() != 0) @(posedge clk);
    repeat (LANES) @(negedge clk); // Room for a stray word to show up.
  endtask

  // Two words of an unfinished frame, then reset before they reach the output.
  task automatic abort_frame_with_reset();
    mac_word_t w;
    for (int wi = 0; wi < 2; wi++) begin
      w = '0;
      w.valid = 1'b1;
      w.data = {$random(seed), $random(seed)};
      w.keep = '1;
      @(negedge clk);
      din = w;
    end
    @(negedge clk);
    arst_n = 1'b0;
    din = '0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
  endtask

  always @(posedge clk) begin
    if (out.valid === 1'b1) compare_output(out);
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the output stream never drained", cycle_limit);
      stop_on_failure();
    end
  end

  initial begin
    int total_words;
    seed = 32'h9182;
    total_words = 2; // Aborted frame.
    foreach (directed_len[i]) frame_len.push_back(directed_len[i]);
    repeat (200) frame_len.push_back(1 + int'($unsigned($random(seed)) % 64));
    frame_len.push_back(5);
    frame_len.push_back(30);
    foreach (frame_len[i]) total_words += (frame_len[i] + LANES - 1) / LANES + 3;
    cycle_limit = 40 * total_words + 200;
    arst_n = 1'b0;
    din = '0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    check_flag("out.valid", 1'b0, out.valid);
    check_flag("overflow", 1'b0, overflow);
    for (int i = 0; i < frame_len.size() - 2; i++) begin
      send_frame(frame_len[i]);
    end
    wait_drain();
    check_flag("overflow", 1'b0, overflow);
    abort_frame_with_reset();
    check_flag("out.valid", 1'b0, out.valid);
    check_flag("overflow", 1'b0, overflow);
    send_frame(frame_len[frame_len.size() - 2]);
    send_frame(frame_len[frame_len.size() - 1]);
    wait_drain();
    check_flag("overflow", 1'b0, overflow);
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: mac_tx_fcs_assertions.sv
`timescale 1ns/1ps

module mac_tx_fcs_assertions (
  input logic               clk,
  input logic               arst_n,
  input logic               pop,
  input logic               empty,
  input mac_pkg::mac_word_t word,
  input logic               overflow
);

  no_pop_when_empty: assert property (@(posedge clk) disable iff (!arst_n)
    !(pop && empty))
    else $error("FIFO popped while empty");

  // Keep must look like 2^n - 1.
  keep_contiguous: assert property (@(posedge clk) disable iff (!arst_n)
    word.valid |-> ((word.keep & (word.keep + 8'd1)) == 8'd0))
    else $error("output keep not contiguous from lane 0");

  keep_not_zero: assert property (@(posedge clk) disable iff (!arst_n)
    word.valid |-> (word.keep != 8'd0))
    else $error("valid output word with empty keep");

  overflow_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    overflow |=> overflow)
    else $error("overflow dropped without reset");

endmodule

bind frame_fifo mac_tx_fcs_assertions i_fifo_checks (
  .clk      (clk),
  .arst_n   (arst_n),
  .pop      (pop),
  .empty    (empty),
  .word     (wdata.word),
  .overflow (overflow)
);

bind fcs_append mac_tx_fcs_assertions i_append_checks (
  .clk      (clk),
  .arst_n   (arst_n),
  .pop      (pop),
  .empty    (empty),
  .word     (out),
  .overflow (1'b0)
);

// File: mac_tx_fcs.sv
`timescale 1ns/1ps

module mac_tx_fcs (
  input  logic               clk,
  input  logic               arst_n,
  input  mac_pkg::mac_word_t din,
  output mac_pkg::mac_word_t out,
  output logic               overflow
);
  import mac_pkg::*;

  mac_word_t   crc_word;
  logic [31:0] crc_fcs;
  fifo_entry_t wr_entry;
  fifo_entry_t head;
  logic        fifo_empty;
  logic        fifo_pop;

  // Word and its FCS arrive in the same cycle.
  assign wr_entry = '{word: crc_word, fcs: crc_fcs};

  mac_hard_crc i_crc (
    .clk     (clk),
    .arst_n  (arst_n),
    .din     (din),
    .dout    (crc_word),
    .crc_out (crc_fcs)
  );

  frame_fifo i_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (crc_word.valid),
    .wdata    (wr_entry),
    .pop      (fifo_pop),
    .rdata    (head),
    .empty    (fifo_empty),
    .overflow (overflow)
  );

  fcs_append i_fcs (
    .clk    (clk),
    .arst_n (arst_n),
    .head   (head),
    .empty  (fifo_empty),
    .pop    (fifo_pop),
    .out    (out)
  );

endmodule

// File: fcs_append.sv
`timescale 1ns/1ps

module fcs_append (
  input  logic                 clk,
  input  logic                 arst_n,
  input  mac_pkg::fifo_entry_t head,
  input  logic                 empty,
  output logic                 pop,
  output mac_pkg::mac_word_t   out
);
  import mac_pkg::*;

  typedef enum logic [1:0] {IDLE, DATA, SPILL} state_e;

  state_e              state_q;
  state_e              state_d;
  logic [3:0]          nbytes;     // Valid bytes in the head word.
  logic [LANES*8-1:0]  lane_mask;
  logic [LANES*8+31:0] merged;     // Data with FCS behind it, spill in the top.
  logic [LANES+3:0]    ext_keep;
  logic                out_valid_q;
  logic                out_last_q;
  logic [LANES-1:0]    out_keep_q;
  logic [LANES*8-1:0]  out_data_q;
  logic [31:0]         spill_data_q;
  logic [3:0]          spill_keep_q;

  assign pop = !empty && (state_q != SPILL);

  always_comb begin
    nbytes    = '0;
    lane_mask = '0;
    for (int i = 0; i < LANES; i++) begin
      if (head.word.keep[i]) begin
        nbytes              = 4'(i + 1);
        lane_mask[8*i +: 8] = 8'hff;
      end
    end
    merged   = {32'b0, head.word.data & lane_mask}
             | ({{(LANES*8){1'b0}}, head.fcs} << (8 * nbytes));
    ext_keep = ((LANES+4)'(1) << (nbytes + 4'd4)) - (LANES+4)'(1);
  end

  always_comb begin
    state_d = state_q;
    if (pop) begin
      if (!head.word.last) state_d = DATA;
      else if (nbytes > 4'd4) state_d = SPILL; // FCS does not fit.
      else state_d = IDLE;
    end else if (state_q == SPILL) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q     <= IDLE;
      out_valid_q <= 1'b0;
      out_last_q  <= 1'b0;
      out_keep_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == SPILL) begin
        out_valid_q <= 1'b1;
        out_last_q  <= 1'b1;
        out_keep_q  <= {{(LANES-4){1'b0}}, spill_keep_q};
      end else if (pop) begin
        out_valid_q <= head.word.valid;
        if (head.word.last) begin
          out_last_q <= (nbytes <= 4'd4);
          out_keep_q <= ext_keep[LANES-1:0];
        end else begin
          out_last_q <= 1'b0;
          out_keep_q <= head.word.keep;
        end
      end else begin
        out_valid_q <= 1'b0;
        out_last_q  <= 1'b0;
        out_keep_q  <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == SPILL) begin
      out_data_q <= {{(LANES*8-32){1'b0}}, spill_data_q};
    end else if (pop) begin
      out_data_q <= head.word.last ? merged[LANES*8-1:0] : head.word.data;
      if (head.word.last) begin
        spill_data_q <= merged[LANES*8 +: 32]; // Leftover FCS bytes.
        spill_keep_q <= ext_keep[LANES +: 4];
      end
    end
  end

  assign out = '{valid: out_valid_q, data: out_data_q, keep: out_keep_q, last: out_last_q};

endmodule

// File: frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 push,
  input  mac_pkg::fifo_entry_t wdata,
  input  logic                 pop,
  output mac_pkg::fifo_entry_t rdata,
  output logic                 empty,
  output logic                 overflow
);
  import mac_pkg::*;

  fifo_entry_t        mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign full    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || do_pop); // Full is fine if a pop frees a slot.
  assign rdata   = mem[rd_ptr];               // Combinational head.

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (push && !do_push) overflow <= 1'b1; // Word dropped, sticky.
    end
  end

endmodule

// File: mac_hard_crc.sv
`timescale 1ns/1ps

module mac_hard_crc (
  input  logic               clk,
  input  logic               arst_n,
  input  mac_pkg::mac_word_t din,
  output mac_pkg::mac_word_t dout,
  output logic [31:0]        crc_out
);
  import mac_pkg::*;
  import crc_pkg::*;

  // Full reversal of the low size bits.
  function automatic logic [63:0] bit_reverse(input logic [63:0] value, input int size);
    logic [63:0] res;
    res = '0;
    for (int i = 0; i < size; i++) begin
      res[i] = value[size - 1 - i];
    end
    return res;
  endfunction

  // Bit order flipped inside each byte.
  function automatic logic [63:0] byte_reverse(input logic [63:0] value, input int size);
    logic [63:0] res;
    res = '0;
    for (int i = 0; i < size; i++) begin
      res[i] = value[(i / 8) * 8 + 7 - (i % 8)];
    end
    return res;
  endfunction

  logic [63:0]        crc_din;
  logic [31:0]        crc_value;
  crc_width_e         crc_width;
  logic               crc_valid;
  logic               sof_q;   // Next valid word opens a frame.
  logic               valid_q;
  logic [LANES*8-1:0] data_q;
  logic [LANES-1:0]   keep_q;
  logic               last_q;

  assign crc_din   = byte_reverse(bit_reverse(din.data, 64), 64); // Byte 0 to top lane.
  assign crc_valid = din.valid && din.keep[0];

  // Highest set lane wins.
  always_comb begin
    crc_width = W1;
    for (int i = 1; i < LANES; i++) begin
      if (din.keep[i]) crc_width = crc_width_e'(i);
    end
  end

  rx_crc64 i_crc (
    .clk        (clk),
    .arst_n     (arst_n),
    .init       (sof_q),
    .data       (crc_din),
    .data_valid (crc_valid),
    .width      (crc_width),
    .crc        (crc_value)
  );

  assign crc_out = ~32'(bit_reverse(byte_reverse({32'b0, crc_value}, 32), 32));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sof_q   <= 1'b1;
      valid_q <= 1'b0;
    end else begin
      valid_q <= din.valid;
      if (din.valid) sof_q <= din.last;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= din.data;
    keep_q <= din.keep;
    last_q <= din.last;
  end

  assign dout = '{valid: valid_q, data: data_q, keep: keep_q, last: last_q};

endmodule

// File: rx_crc64.sv
`timescale 1ns/1ps

module rx_crc64 (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                init,
  input  logic [63:0]         data,
  input  logic                data_valid,
  input  crc_pkg::crc_width_e width,
  output logic [31:0]         crc
);
  import crc_pkg::*;

  function automatic logic [31:0] reflect32(input logic [31:0] value);
    logic [31:0] res;
    for (int i = 0; i < 32; i++) begin
      res[i] = value[31 - i];
    end
    return res;
  endfunction

  // Register holds the CRC in lane order, first byte high.
  function automatic logic [31:0] swap_bytes(input logic [31:0] value);
    return {value[7:0], value[15:8], value[23:16], value[31:24]};
  endfunction

  localparam logic [31:0] POLY_REFL = reflect32(CRC_POLY);

  logic [31:0] crc_q;
  logic [31:0] acc;
  logic [31:0] crc_next;

  // Bytes enter from the top lane down, LSB first within each byte.
  always_comb begin
    acc = swap_bytes(init ? CRC_INIT : crc_q); // Restart on frame start.
    for (int b = 0; b < 8; b++) begin
      if (b <= int'(width)) begin
        acc = acc ^ {24'b0, data[63 - 8*b -: 8]};
        for (int i = 0; i < 8; i++) begin
          acc = acc[0] ? ((acc >> 1) ^ POLY_REFL) : (acc >> 1);
        end
      end
    end
    crc_next = swap_bytes(acc);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      crc_q <= CRC_INIT;
    end else if (data_valid) begin
      crc_q <= crc_next;
    end
  end

  assign crc = crc_q;

endmodule

// File: crc_pkg.sv
package crc_pkg;

  // Normal form, reflected inside the engine.
  localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;
  localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

  // Valid bytes minus one.
  typedef enum logic [2:0] {
    W1 = 3'd0,
    W2 = 3'd1,
    W3 = 3'd2,
    W4 = 3'd3,
    W5 = 3'd4,
    W6 = 3'd5,
    W7 = 3'd6,
    W8 = 3'd7
  } crc_width_e;

endpackage

// File: mac_pkg.sv
package mac_pkg;

  localparam int LANES      = 8; // Bytes per bus word.
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = 2;

  // One bus word, byte 0 in the low bits.
  typedef struct packed {
    logic                 valid;
    logic [LANES*8-1:0]   data;
    logic [LANES-1:0]     keep; // Contiguous from lane 0.
    logic                 last;
  } mac_word_t;

  // FIFO entry, fcs only meaningful on a last word.
  typedef struct packed {
    mac_word_t   word;
    logic [31:0] fcs;
  } fifo_entry_t;

endpackage
